// File: source/scan_pkg.sv
package scan_pkg;

    // pixel widths
    localparam int game_rgb_w = 12;         // 4 bits per channel from the game
    localparam int vga_ch_w   = 5;          // one VGA colour channel

    // VGA horizontal timing in clk_vga cycles
    localparam logic [6:0] h_sync_len  = 7'd96;  // free-running sync pulse
    localparam logic [6:0] h_front_len = 7'd16;  // after sync, before border
    localparam logic [6:0] h_left_len  = 7'd64;  // blank left border
    localparam logic [6:0] h_back_len  = 7'd48;  // after the active pixels

    // horizontal line phases
    typedef enum logic [1:0] {
        h_sync  = 2'd0,
        h_front = 2'd1,
        h_line  = 2'd2,
        h_back  = 2'd3
    } h_state_t;

endpackage

// File: source/line_writer.sv
module line_writer import scan_pkg::*; #(
    parameter int  line_pixels = 256,
    localparam int aw          = $clog2(line_pixels)
) (
    input  logic                  clk_vga,
    input  logic                  rst,
    input  logic                  cen_pxl,
    input  logic                  lhbl,
    input  logic [3:0]            red,
    input  logic [3:0]            green,
    input  logic [3:0]            blue,
    output logic [aw-1:0]         wr_addr,
    output logic [game_rgb_w-1:0] wr_data,
    output logic [1:0]            wr_en,
    output logic                  wr_sel,
    output logic                  lhbl_rise
);

    logic lhbl_l;   // lhbl one cycle ago
    logic wr_go;    // a pixel is written this cycle

    assign wr_data   = {red, green, blue};
    assign lhbl_rise = lhbl && !lhbl_l;

    // only during the active line, so blanking leaves address 0 alone
    assign wr_go = cen_pxl && lhbl;

    assign wr_en[0] = wr_go && !wr_sel;
    assign wr_en[1] = wr_go && wr_sel;

    always_ff @(posedge clk_vga) begin
        if (rst) begin
            lhbl_l  <= 1'b0;
            wr_sel  <= 1'b0;
            wr_addr <= '0;
        end else begin
            lhbl_l <= lhbl;
            if (!lhbl) begin
                wr_addr <= '0;
                if (lhbl_l) begin
                    wr_sel <= ~wr_sel;  // next line goes to the other buffer
                end
            end else if (cen_pxl) begin
                wr_addr <= wr_addr + 1'b1;
            end
        end
    end

endmodule

// File: source/line_buffer.sv
module line_buffer import scan_pkg::*; #(
    parameter int  line_pixels = 256,
    localparam int aw          = $clog2(line_pixels)
) (
    input  logic                  clk_vga,
    input  logic                  wr_en,
    input  logic [aw-1:0]         wr_addr,
    input  logic [game_rgb_w-1:0] wr_data,
    input  logic [aw-1:0]         rd_addr,
    output logic [game_rgb_w-1:0] rd_data
);

    logic [game_rgb_w-1:0] mem [line_pixels];   // one game line

    // write port, game side
    always_ff @(posedge clk_vga) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // read port, one cycle latency
    always_ff @(posedge clk_vga) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// File: source/vga_timing.sv
module vga_timing import scan_pkg::*; #(
    parameter int  line_pixels = 256,
    localparam int aw          = $clog2(line_pixels)
) (
    input  logic          clk_vga,
    input  logic          rst,
    input  logic          lvbl,
    input  logic          lhbl_rise,
    input  logic          wr_sel,
    output logic [aw-1:0] rd_addr,
    output logic          rd_sel,
    output logic          scanline,
    output logic          de_early,
    output logic          hsync_early,
    output logic          vga_vsync
);

    h_state_t   state;
    logic [6:0] cnt;        // shared phase counter
    logic       lock_line;  // sync end waits for the game line start
    logic       active;     // left border done
    logic       half;       // second copy of the current pixel
    logic       lvbl_l;
    logic       vsync_req;  // lvbl fell, vsync starts at the next sync
    logic       vsync_cnt;  // second vsync line pending
    logic       sync_done;
    logic       last_pxl;

    assign sync_done   = lock_line ? lhbl_rise : (cnt == 7'd0);
    assign last_pxl    = half && (rd_addr == aw'(line_pixels - 1));
    assign de_early    = (state == h_line) && active;
    assign hsync_early = (state != h_sync);

    always_ff @(posedge clk_vga) begin
        if (rst) begin
            lvbl_l    <= 1'b1;
            vsync_req <= 1'b0;
        end else begin
            lvbl_l    <= lvbl;
            vsync_req <= vga_vsync && (vsync_req || (lvbl_l && !lvbl));
        end
    end

    always_ff @(posedge clk_vga) begin
        if (rst) begin
            state     <= h_sync;
            cnt       <= h_sync_len - 7'd1;
            lock_line <= 1'b0;
            active    <= 1'b0;
            half      <= 1'b0;
            rd_addr   <= '0;
            rd_sel    <= 1'b0;
            scanline  <= 1'b0;
            vga_vsync <= 1'b1;
            vsync_cnt <= 1'b1;
        end else begin
            case (state)
                h_sync: begin
                    cnt <= cnt - 7'd1;  // ignored on lock lines
                    if (sync_done) begin
                        state     <= h_front;
                        cnt       <= h_front_len - 7'd1;
                        lock_line <= ~lock_line;
                        scanline  <= ~scanline;     // high on the repeat line
                        if (lock_line) begin
                            rd_sel <= ~wr_sel;      // the line just completed
                        end
                    end
                end
                h_front: begin
                    cnt <= cnt - 7'd1;
                    if (cnt == 7'd0) begin
                        state   <= h_line;
                        cnt     <= h_left_len - 7'd1;
                        active  <= 1'b0;
                        half    <= 1'b0;
                        rd_addr <= '0;
                    end
                end
                h_line: begin
                    if (!active) begin
                        cnt <= cnt - 7'd1;  // left border
                        if (cnt == 7'd0) begin
                            active <= 1'b1;
                        end
                    end else if (last_pxl) begin
                        state  <= h_back;
                        cnt    <= h_back_len - 7'd1;
                        active <= 1'b0;
                    end else begin
                        half <= ~half;
                        if (half) begin
                            rd_addr <= rd_addr + 1'b1;
                        end
                    end
                end
                h_back: begin
                    cnt <= cnt - 7'd1;
                    if (cnt == 7'd0) begin
                        state <= h_sync;
                        cnt   <= h_sync_len - 7'd1;
                        if (vsync_req) begin
                            vga_vsync <= 1'b0;      // first of the two vsync lines
                            vsync_cnt <= 1'b0;
                        end else begin
                            vga_vsync <= vsync_cnt; // second line low, then back up
                            vsync_cnt <= 1'b1;
                        end
                    end
                end
                default: state <= h_sync;
            endcase
        end
    end

endmodule

// File: source/line_mixer.sv
module line_mixer import scan_pkg::*; (
    input  logic                  clk_vga,
    input  logic                  rst,
    input  logic                  en_mixing,
    input  logic                  scanline,
    input  logic                  rd_sel,
    input  logic                  de_early,
    input  logic                  hsync_early,
    input  logic [game_rgb_w-1:0] rd_data0,
    input  logic [game_rgb_w-1:0] rd_data1,
    output logic [vga_ch_w-1:0]   vga_red,
    output logic [vga_ch_w-1:0]   vga_green,
    output logic [vga_ch_w-1:0]   vga_blue,
    output logic                  vga_hsync,
    output logic                  vga_de
);

    logic                  de_d;        // aligned with rd_data
    logic                  hsync_d;
    logic [3*vga_ch_w-1:0] wide0;
    logic [3*vga_ch_w-1:0] wide1;
    logic [3*vga_ch_w-1:0] mix;
    logic [3*vga_ch_w-1:0] pix;

    // 4 to 5 bits, top bit repeated into the lsb
    function automatic logic [3*vga_ch_w-1:0] widen(input logic [game_rgb_w-1:0] rgb);
        return {rgb[11:8], rgb[11], rgb[7:4], rgb[7], rgb[3:0], rgb[3]};
    endfunction

    function automatic logic [vga_ch_w-1:0] avg(input logic [vga_ch_w-1:0] a,
                                                 input logic [vga_ch_w-1:0] b);
        logic [vga_ch_w:0] sum;
        sum = {1'b0, a} + {1'b0, b};
        return sum[vga_ch_w:1];     // rounded down
    endfunction

    assign wide0 = widen(rd_data0);
    assign wide1 = widen(rd_data1);

    always_comb begin
        for (int i = 0; i < 3; i++) begin
            mix[i*vga_ch_w +: vga_ch_w] = avg(wide0[i*vga_ch_w +: vga_ch_w],
                                              wide1[i*vga_ch_w +: vga_ch_w]);
        end
    end

    assign pix = (scanline && en_mixing) ? mix : (rd_sel ? wide1 : wide0);

    always_ff @(posedge clk_vga) begin
        if (rst) begin
            de_d      <= 1'b0;
            vga_de    <= 1'b0;
            hsync_d   <= 1'b1;
            vga_hsync <= 1'b1;
        end else begin
            de_d      <= de_early;
            vga_de    <= de_d;
            hsync_d   <= hsync_early;
            vga_hsync <= hsync_d;
        end
    end

    always_ff @(posedge clk_vga) begin
        {vga_red, vga_green, vga_blue} <= de_d ? pix : '0;   // black outside de
    end

endmodule

// File: source/scan_doubler_top.sv
module scan_doubler_top import scan_pkg::*; #(
    parameter int  line_pixels = 256,
    localparam int aw          = $clog2(line_pixels)
) (
    input  logic                clk_vga,
    input  logic                rst,
    input  logic [3:0]          red,
    input  logic [3:0]          green,
    input  logic [3:0]          blue,
    input  logic                cen_pxl,
    input  logic                lhbl,
    input  logic                lvbl,
    input  logic                en_mixing,
    output logic [vga_ch_w-1:0] vga_red,
    output logic [vga_ch_w-1:0] vga_green,
    output logic [vga_ch_w-1:0] vga_blue,
    output logic                vga_hsync,
    output logic                vga_vsync,
    output logic                vga_de
);

    logic [aw-1:0]         wr_addr;
    logic [game_rgb_w-1:0] wr_data;
    logic [1:0]            wr_en;
    logic                  wr_sel;
    logic                  lhbl_rise;
    logic [aw-1:0]         rd_addr;
    logic [game_rgb_w-1:0] rd_data [2];
    logic                  rd_sel;
    logic                  scanline;
    logic                  de_early;
    logic                  hsync_early;

    line_writer #(.line_pixels(line_pixels)) i_writer (
        .clk_vga   (clk_vga),
        .rst       (rst),
        .cen_pxl   (cen_pxl),
        .lhbl      (lhbl),
        .red       (red),
        .green     (green),
        .blue      (blue),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .wr_en     (wr_en),
        .wr_sel    (wr_sel),
        .lhbl_rise (lhbl_rise)
    );

    // ping-pong line buffers
    for (genvar i = 0; i < 2; i++) begin : g_buf
        line_buffer #(.line_pixels(line_pixels)) i_buf (
            .clk_vga (clk_vga),
            .wr_en   (wr_en[i]),
            .wr_addr (wr_addr),
            .wr_data (wr_data),
            .rd_addr (rd_addr),
            .rd_data (rd_data[i])
        );
    end

    vga_timing #(.line_pixels(line_pixels)) i_timing (
        .clk_vga     (clk_vga),
        .rst         (rst),
        .lvbl        (lvbl),
        .lhbl_rise   (lhbl_rise),
        .wr_sel      (wr_sel),
        .rd_addr     (rd_addr),
        .rd_sel      (rd_sel),
        .scanline    (scanline),
        .de_early    (de_early),
        .hsync_early (hsync_early),
        .vga_vsync   (vga_vsync)
    );

    line_mixer i_mixer (
        .clk_vga     (clk_vga),
        .rst         (rst),
        .en_mixing   (en_mixing),
        .scanline    (scanline),
        .rd_sel      (rd_sel),
        .de_early    (de_early),
        .hsync_early (hsync_early),
        .rd_data0    (rd_data[0]),
        .rd_data1    (rd_data[1]),
        .vga_red     (vga_red),
        .vga_green   (vga_green),
        .vga_blue    (vga_blue),
        .vga_hsync   (vga_hsync),
        .vga_de      (vga_de)
    );

endmodule

// File: verif/scan_doubler_tb.sv
module scan_doubler_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int line_pixels  = 256;
    localparam int vga_pixels   = 2 * line_pixels;
    localparam int blank_cycles = 576;
    localparam int line_cycles  = 4 * line_pixels + blank_cycles;   // 1600
    localparam int frame_lines  = 12;
    localparam int n_frames     = 3;
    localparam int n_lines      = n_frames * frame_lines + 1;   // last one flushes the display
    localparam int clk_ns       = 8;
    localparam int timeout_ns   = (n_frames * frame_lines + 6) * line_cycles * clk_ns;

    logic       clk_vga;
    logic       rst;
    logic [3:0] red;
    logic [3:0] green;
    logic [3:0] blue;
    logic       cen_pxl;
    logic       lhbl;
    logic       lvbl;
    logic       en_mixing;
    logic [4:0] vga_red;
    logic [4:0] vga_green;
    logic [4:0] vga_blue;
    logic       vga_hsync;
    logic       vga_vsync;
    logic       vga_de;

    logic [11:0] pix_mem [n_lines][line_pixels];    // game pixels per line
    logic [14:0] cap_pix [vga_pixels];              // one captured VGA line
    time         cap_t   [vga_pixels];
    int          lines_stored;
    int          lines_checked;
    int          cur_line = -1;
    bit          next_mix;
    int          free_pulses;
    int          vs_pulses;
    int          errs [5];
    string       test_name [5] = '{"reset state", "horizontal timing", "line doubling",
                                   "line mixing", "vertical sync"};

    scan_doubler_top #(.line_pixels(line_pixels)) i_dut (
        .clk_vga   (clk_vga),
        .rst       (rst),
        .red       (red),
        .green     (green),
        .blue      (blue),
        .cen_pxl   (cen_pxl),
        .lhbl      (lhbl),
        .lvbl      (lvbl),
        .en_mixing (en_mixing),
        .vga_red   (vga_red),
        .vga_green (vga_green),
        .vga_blue  (vga_blue),
        .vga_hsync (vga_hsync),
        .vga_vsync (vga_vsync),
        .vga_de    (vga_de)
    );

    initial begin
        clk_vga = 1'b0;
        forever #(clk_ns / 2) clk_vga = ~clk_vga;
    end

    initial begin
        #(timeout_ns);
        $display("watchdog: the run did not finish within %0d ns", timeout_ns);
        $display("CHECKS FAILED");
        $finish;
    end

    task automatic value_error(input int t, input string sig, input logic [14:0] exp,
                               input logic [14:0] got, input time when);
        errs[t]++;
        $display("** Error at %0d ns: %s expected 0x%04h, got 0x%04h", when, sig, exp, got);
    endtask

    task automatic count_error(input int t, input string sig, input int exp, input int got);
        errs[t]++;
        $display("** Error at %0d ns: %s expected %0d, got %0d", $time, sig, exp, got);
    endtask

    task automatic fault(input int t, input string msg);
        errs[t]++;
        $display("failure at %0d ns: %s", $time, msg);
    endtask

    task automatic report_test(input int t);
        if (errs[t] == 0) begin
            $display("test %0d %s: passed", t, test_name[t]);
        end else begin
            $display("test %0d %s: failed with %0d errors", t, test_name[t], errs[t]);
        end
    endtask

    // each channel doubled plus its msb, blended with the next game line if mixed
    function automatic logic [14:0] expected_pixel(input int line, input bit mixed, input int idx);
        logic [11:0] a;
        logic [11:0] b;
        logic [14:0] res;
        int          va;
        int          vb;
        a = pix_mem[line][idx / 2];
        b = mixed ? pix_mem[line + 1][idx / 2] : a;
        res = '0;
        for (int ch = 0; ch < 3; ch++) begin
            va = int'(a[ch*4 +: 4]) * 2 + int'(a[ch*4 + 3]);
            vb = int'(b[ch*4 +: 4]) * 2 + int'(b[ch*4 + 3]);
            res[ch*5 +: 5] = 5'((va + vb) / 2);
        end
        return res;
    endfunction

    // game line whose first pixels match the capture, -1 if none
    function automatic int find_line();
        bit ok;
        for (int l = 0; l < lines_stored; l++) begin
            ok = 1'b1;
            for (int k = 0; k < 8; k++) begin
                if (cap_pix[k] != expected_pixel(l, 1'b0, k)) begin
                    ok = 1'b0;
                end
            end
            if (ok) begin
                return l;
            end
        end
        return -1;
    endfunction

    task automatic check_line(input logic mode);
        int          l;
        bit          mixed;
        logic [14:0] exp;
        l = find_line();
        mixed = (cur_line >= 0) && next_mix;
        if (cur_line < 0) begin
            if (l < 0) begin
                return;     // buffers still hold no complete line
            end
            cur_line = l;
        end else if (!mixed) begin
            if (l != cur_line + 1) begin
                fault(2, $sformatf("game line %0d shown, line %0d expected", l, cur_line + 1));
            end
            cur_line++;
        end
        for (int k = 0; k < vga_pixels; k++) begin
            exp = expected_pixel(cur_line, mixed && mode, k);
            if (cap_pix[k] != exp) begin
                value_error(mixed ? 3 : 2,
                            $sformatf("{vga_red,vga_green,vga_blue} line %0d pixel %0d",
                                      cur_line, k),
                            exp, cap_pix[k], cap_t[k]);
            end
        end
        next_mix = !mixed;
        lines_checked++;
    endtask

    task automatic drive_game_line(input int line);
        for (int k = 0; k < line_pixels; k++) begin
            pix_mem[line][k] = 12'($urandom);
        end
        lines_stored = line + 1;
        lvbl = (line % frame_lines) < frame_lines - 1;  // low on the last line of a frame
        for (int c = 0; c < line_cycles; c++) begin
            cen_pxl = (c % 4) == 0;
            lhbl    = c >= blank_cycles;
            if (c == blank_cycles) begin
                en_mixing = (line / frame_lines) != 1;  // middle frame unmixed
            end
            if (lhbl) begin
                {red, green, blue} = pix_mem[line][(c - blank_cycles) / 4];
            end else begin
                {red, green, blue} = 12'h000;
            end
            @(negedge clk_vga);
        end
    endtask

    initial begin : monitor
        logic prev_hs;
        logic prev_vs;
        logic prev_de;
        logic prev_lvbl;
        logic cap_mode;
        int   cyc;
        int   cap_n;
        int   width;
        int   n_hs;
        int   hs_fall;
        int   vs_fall;
        int   vs_rise;
        int   vs_hfalls;
        bit   vs_low;
        bit   vs_after;
        bit   lvbl_pending;
        bit   last_free;
        bit   reset_done;
        prev_hs = 1'b1;
        prev_vs = 1'b1;
        prev_de = 1'b0;
        prev_lvbl = 1'b1;
        cap_mode = 1'b0;
        cyc = 0;
        cap_n = 0;
        n_hs = 0;
        hs_fall = 0;
        vs_fall = 0;
        vs_rise = 0;
        vs_hfalls = 0;
        vs_low = 1'b0;
        vs_after = 1'b0;
        lvbl_pending = 1'b0;
        last_free = 1'b0;
        reset_done = 1'b0;
        wait (!rst);
        forever begin
            @(negedge clk_vga);
            cyc++;
            if (!vga_de && {vga_red, vga_green, vga_blue} != 15'd0) begin
                value_error(1, "{vga_red,vga_green,vga_blue} outside vga_de", 15'd0,
                            {vga_red, vga_green, vga_blue}, $time);
            end
            if (vga_de && !vga_hsync) begin
                fault(1, "vga_de is high during hsync");
            end
            if (vga_de && n_hs == 0) begin
                fault(0, "vga_de went high before the first line");
            end
            if (vga_de && !prev_de && !reset_done) begin
                report_test(0);
                reset_done = 1'b1;
            end
            if (prev_lvbl && !lvbl) begin
                lvbl_pending = 1'b1;
            end
            if (prev_hs && !vga_hsync) begin
                hs_fall = cyc;
                if (vs_low) begin
                    vs_hfalls++;
                    if (vs_hfalls == 1 && cyc - vs_fall != 2) begin
                        count_error(4, "cycles from vga_vsync fall to hsync", 2, cyc - vs_fall);
                    end
                end
                if (vs_after) begin
                    if (cyc - vs_rise != 2) begin
                        count_error(4, "cycles from vga_vsync rise to hsync", 2, cyc - vs_rise);
                    end
                    vs_after = 1'b0;
                end
            end
            if (!prev_hs && vga_hsync) begin
                width = cyc - hs_fall;
                if (width < 96) begin
                    count_error(1, "vga_hsync low cycles", 96, width);
                end else if (n_hs > 0 && (width == 96) == last_free) begin
                    fault(1, "free-running and locked hsync pulses do not alternate");
                end
                last_free = width == 96;
                if (last_free) begin
                    free_pulses++;
                end
                n_hs++;
            end
            if (prev_vs && !vga_vsync) begin
                if (!lvbl_pending) begin
                    fault(4, "vga_vsync fell without a falling lvbl");
                end
                lvbl_pending = 1'b0;
                vs_low = 1'b1;
                vs_fall = cyc;
                vs_hfalls = 0;
            end
            if (!prev_vs && vga_vsync) begin
                if (vs_hfalls != 2) begin
                    count_error(4, "hsync periods in vga_vsync pulse", 2, vs_hfalls);
                end
                vs_low = 1'b0;
                vs_after = 1'b1;
                vs_rise = cyc;
                vs_pulses++;
            end
            if (vga_de) begin
                if (!prev_de) begin
                    cap_mode = en_mixing;   // only changes in hsync
                end
                if (cap_n < vga_pixels) begin
                    cap_pix[cap_n] = {vga_red, vga_green, vga_blue};
                    cap_t[cap_n] = $time;
                end
                cap_n++;
            end else if (prev_de) begin
                if (cap_n != vga_pixels) begin
                    count_error(1, "vga_de cycles per line", vga_pixels, cap_n);
                end else begin
                    check_line(cap_mode);
                end
                cap_n = 0;
            end
            prev_hs = vga_hsync;
            prev_vs = vga_vsync;
            prev_de = vga_de;
            prev_lvbl = lvbl;
        end
    end

    initial begin
        int total;
        int failed;
        void'($urandom(32'h6a64bdd6));
        rst = 1'b1;
        red = 4'h0;
        green = 4'h0;
        blue = 4'h0;
        cen_pxl = 1'b0;
        lhbl = 1'b0;
        lvbl = 1'b1;
        en_mixing = 1'b1;
        lines_stored = 0;
        lines_checked = 0;
        repeat (8) @(negedge clk_vga);
        if (vga_hsync !== 1'b1 || vga_vsync !== 1'b1 || vga_de !== 1'b0) begin
            fault(0, "syncs not high or vga_de not low in reset");
        end
        rst = 1'b0;
        for (int line = 0; line < n_lines; line++) begin
            drive_game_line(line);
        end
        lhbl = 1'b0;
        cen_pxl = 1'b0;
        wait (lines_checked >= 2 * (n_lines - 1));  // every game line shown twice
        if (free_pulses < n_lines - 1) begin
            count_error(1, "free-running hsync pulses", n_lines - 1, free_pulses);
        end
        if (vs_pulses != n_frames) begin
            count_error(4, "vga_vsync pulses", n_frames, vs_pulses);
        end
        total = 0;
        failed = 0;
        for (int t = 1; t < 5; t++) begin
            report_test(t);
        end
        for (int t = 0; t < 5; t++) begin
            total += errs[t];
            if (errs[t] != 0) begin
                failed++;
            end
        end
        $display("5 tests, %0d failed, %0d errors, %0d lines compared", failed, total,
                 lines_checked);
        if (total == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: sources.f
source/scan_pkg.sv
source/line_writer.sv
source/line_buffer.sv
source/vga_timing.sv
source/line_mixer.sv
source/scan_doubler_top.sv
verif/scan_doubler_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
    --top-module scan_doubler_tb \
    -Mdir obj_dir -o scan_doubler_sim \
    -f sources.f

./obj_dir/scan_doubler_sim | tee sim.log

if grep -q "CHECKS FAILED" sim.log; then
    echo "simulation reported failures, see sim.log"
    exit 1
fi

echo "simulation finished without failures"
